// ==== source/nf_ahb_pkg.sv ====
// AHB-Lite bus types and address map
`default_nettype none

package nf_ahb_pkg;

    typedef logic [31 : 0] ahb_word_t;              // address and data word

    typedef enum logic [1 : 0] {
        htrans_idle   = 2'b00,                      // no transfer
        htrans_nonseq = 2'b10                       // single transfer
    } htrans_t;

    typedef logic [2 : 0] hsize_t;                  // transfer size field
    localparam hsize_t hsize_word = 3'b010;         // 32-bit, the only size used

    typedef enum logic {
        hresp_okay  = 1'b0,
        hresp_error = 1'b1                          // never returned here
    } hresp_t;

    // slave index, same encoding as address bits 17:16
    typedef enum logic [1 : 0] {
        slv_ram  = 2'd0,
        slv_gpio = 2'd1,
        slv_pwm  = 2'd2,
        slv_none = 2'd3                             // unmapped region
    } slave_idx_t;

    localparam int slave_c = 3;                     // mapped slaves
    localparam int map_msb = 17;                    // region select, high bit
    localparam int map_lsb = 16;                    // region select, low bit

    // address to slave index
    function automatic slave_idx_t decode_slave(input ahb_word_t addr);
        return slave_idx_t'(addr[map_msb : map_lsb]);
    endfunction

endpackage : nf_ahb_pkg

`default_nettype wire

// ==== source/nf_periph_pkg.sv ====
// GPIO and PWM register map
`default_nettype none

package nf_periph_pkg;

    // GPIO register offsets
    localparam logic [7 : 0] gpio_gpi_off = 8'h00;  // input pins, read only
    localparam logic [7 : 0] gpio_gpo_off = 8'h04;  // output value
    localparam logic [7 : 0] gpio_gpd_off = 8'h08;  // direction

    // PWM register offsets
    localparam logic [7 : 0] pwm_duty_off = 8'h00;  // duty value

    typedef logic [7 : 0] gpio_word_t;              // default GPIO port width
    typedef logic [7 : 0] pwm_duty_t;               // default duty width

endpackage : nf_periph_pkg

`default_nettype wire

// ==== source/nf_ahb_if.sv ====
// AHB-Lite slave connection
`timescale 1ns/1ps
`default_nettype none

interface nf_ahb_if
    import nf_ahb_pkg::*;
;

    ahb_word_t  haddr;                              // transfer address
    ahb_word_t  hwdata;                             // write data, data phase
    ahb_word_t  hrdata;                             // read data, data phase
    logic       hwrite;                             // 1 = write
    htrans_t    htrans;                             // transfer type
    hsize_t     hsize;                              // transfer size
    logic       hsel;                               // slave select
    hresp_t     hresp;                              // slave response
    logic       hready;                             // slave ready out

    // router side
    modport master (
        output haddr, hwdata, hwrite, htrans, hsize, hsel,
        input  hrdata, hresp, hready
    );

    // peripheral side
    modport slave (
        input  haddr, hwdata, hwrite, htrans, hsize, hsel,
        output hrdata, hresp, hready
    );

endinterface : nf_ahb_if

`default_nettype wire

// ==== source/nf_ahb_router.sv ====
// core port to AHB-Lite router
`timescale 1ns/1ps
`default_nettype none

module nf_ahb_router
    import nf_ahb_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    // core side
    input  ahb_word_t   addr_dm_i,                  // request address
    input  ahb_word_t   wd_dm_i,                    // write data
    input  logic        we_dm_i,                    // write enable
    input  logic        req_dm_i,                   // request held until ack
    output ahb_word_t   rd_dm_o,                    // read data valid with ack
    output logic        req_ack_dm_o,               // one-cycle ack
    // slave side
    nf_ahb_if.master    ram_m,
    nf_ahb_if.master    gpio_m,
    nf_ahb_if.master    pwm_m
);

    typedef enum logic [1 : 0] {
        st_idle,                                    // waiting for request
        st_addr,                                    // address phase
        st_data                                     // data phase
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    ahb_word_t              addr_r;                 // latched request
    ahb_word_t              wd_r;
    logic                   we_r;
    slave_idx_t             sel_r;                  // decoded slave kept for data phase
    logic [slave_c-1 : 0]   hsel_vec;               // one bit per mapped slave
    htrans_t                htrans_c;
    ahb_word_t              sel_hrdata;             // read data of selected slave
    hresp_t                 sel_hresp;
    logic                   sel_hready;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= st_idle;
            sel_r <= slv_none;
        end else begin
            state <= state_nxt;
            if (state == st_idle && req_dm_i)
                sel_r <= decode_slave(addr_dm_i);   // region from bits 17:16
        end
    end

    // request payload for the transfer
    always_ff @(posedge clk_i) begin
        if (state == st_idle && req_dm_i) begin
            addr_r <= addr_dm_i;
            wd_r   <= wd_dm_i;
            we_r   <= we_dm_i;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle : if (req_dm_i) state_nxt = st_addr;
            st_addr : state_nxt = st_data;
            st_data : if (sel_hready) state_nxt = st_idle;  // back to idle without re-sampling
            default : state_nxt = st_idle;
        endcase
    end

    // one-hot select during address phase only
    always_comb begin
        for (int i = 0; i < slave_c; i++)
            hsel_vec[i] = (state == st_addr) && (sel_r == slave_idx_t'(i));
    end

    assign htrans_c = (state == st_addr) ? htrans_nonseq : htrans_idle;

    assign ram_m.haddr   = addr_r;
    assign ram_m.hwdata  = wd_r;
    assign ram_m.hwrite  = we_r;
    assign ram_m.htrans  = htrans_c;
    assign ram_m.hsize   = hsize_word;
    assign ram_m.hsel    = hsel_vec[slv_ram];

    assign gpio_m.haddr  = addr_r;
    assign gpio_m.hwdata = wd_r;
    assign gpio_m.hwrite = we_r;
    assign gpio_m.htrans = htrans_c;
    assign gpio_m.hsize  = hsize_word;
    assign gpio_m.hsel   = hsel_vec[slv_gpio];

    assign pwm_m.haddr   = addr_r;
    assign pwm_m.hwdata  = wd_r;
    assign pwm_m.hwrite  = we_r;
    assign pwm_m.htrans  = htrans_c;
    assign pwm_m.hsize   = hsize_word;
    assign pwm_m.hsel    = hsel_vec[slv_pwm];

    // data phase response mux
    always_comb begin
        case (sel_r)
            slv_ram  : begin
                sel_hrdata = ram_m.hrdata;
                sel_hresp  = ram_m.hresp;
                sel_hready = ram_m.hready;
            end
            slv_gpio : begin
                sel_hrdata = gpio_m.hrdata;
                sel_hresp  = gpio_m.hresp;
                sel_hready = gpio_m.hready;
            end
            slv_pwm  : begin
                sel_hrdata = pwm_m.hrdata;
                sel_hresp  = pwm_m.hresp;
                sel_hready = pwm_m.hready;
            end
            default  : begin
                sel_hrdata = '0;                    // unmapped reads zero
                sel_hresp  = hresp_okay;
                sel_hready = 1'b1;
            end
        endcase
    end

    assign req_ack_dm_o = (state == st_data) && sel_hready;
    assign rd_dm_o      = (state == st_data) ? sel_hrdata : '0;

    // core must still hold its request when acked
    a_ack_has_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_ack_dm_o |-> req_dm_i);

    a_hsel_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(hsel_vec));

    // slaves never flag an error on a completed transfer
    a_resp_okay : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state == st_data && sel_hready) |-> sel_hresp == hresp_okay);

endmodule : nf_ahb_router

`default_nettype wire

// ==== source/nf_ahb_ram.sv ====
// AHB-Lite word RAM
`timescale 1ns/1ps
`default_nettype none

module nf_ahb_ram
    import nf_ahb_pkg::*;
#(
    parameter int ram_depth = 256                   // words
)(
    input  logic        clk_i,
    input  logic        rst_n_i,
    nf_ahb_if.slave     ahb_s
);

    localparam int addr_w = $clog2(ram_depth);

    ahb_word_t              mem [ram_depth];        // storage
    logic [addr_w-1 : 0]    addr_r;                 // word index from address phase
    logic                   act_r;                  // data phase active
    logic                   wr_r;                   // data phase is a write
    logic                   addr_ph;

    assign addr_ph = ahb_s.hsel && (ahb_s.htrans == htrans_nonseq);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            act_r <= 1'b0;
            wr_r  <= 1'b0;
        end else begin
            act_r <= addr_ph;
            wr_r  <= addr_ph && ahb_s.hwrite;
        end
    end

    always_ff @(posedge clk_i) begin
        if (addr_ph)
            addr_r <= ahb_s.haddr[addr_w+1 : 2];    // byte to word address
    end

    always_ff @(posedge clk_i) begin
        if (wr_r)
            mem[addr_r] <= ahb_s.hwdata;            // hwdata valid in data phase
    end

    assign ahb_s.hrdata = act_r ? mem[addr_r] : '0;
    assign ahb_s.hresp  = hresp_okay;
    assign ahb_s.hready = 1'b1;                     // zero wait states

    // word index would wrap otherwise
    a_addr_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        addr_ph |-> (ahb_s.haddr[15 : 2] < ram_depth));

endmodule : nf_ahb_ram

`default_nettype wire

// ==== source/nf_ahb_gpio.sv ====
// AHB-Lite GPIO port
`timescale 1ns/1ps
`default_nettype none

module nf_ahb_gpio
    import nf_ahb_pkg::*;
    import nf_periph_pkg::*;
#(
    parameter int gpio_w = 8                        // pins
)(
    input  logic                clk_i,
    input  logic                rst_n_i,
    nf_ahb_if.slave             ahb_s,
    input  logic [gpio_w-1 : 0] gpi_i,              // input pins
    output logic [gpio_w-1 : 0] gpo_o,              // output value
    output logic [gpio_w-1 : 0] gpd_o               // direction
);

    logic [gpio_w-1 : 0]    gpo_r;
    logic [gpio_w-1 : 0]    gpd_r;
    logic [gpio_w-1 : 0]    gpi_m;                  // first sync stage
    logic [gpio_w-1 : 0]    gpi_s;                  // synced inputs
    logic [7 : 0]           off_r;                  // register offset
    logic                   act_r;
    logic                   wr_r;
    logic                   addr_ph;

    assign addr_ph = ahb_s.hsel && (ahb_s.htrans == htrans_nonseq);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            act_r <= 1'b0;
            wr_r  <= 1'b0;
            gpi_m <= '0;
            gpi_s <= '0;
        end else begin
            act_r <= addr_ph;
            wr_r  <= addr_ph && ahb_s.hwrite;
            gpi_m <= gpi_i;                         // two-flop sync
            gpi_s <= gpi_m;
        end
    end

    always_ff @(posedge clk_i) begin
        if (addr_ph)
            off_r <= ahb_s.haddr[7 : 0];
    end

    // register writes land at end of data phase
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpo_r <= '0;
            gpd_r <= '0;
        end else if (wr_r) begin
            if (off_r == gpio_gpo_off)
                gpo_r <= ahb_s.hwdata[gpio_w-1 : 0];
            if (off_r == gpio_gpd_off)
                gpd_r <= ahb_s.hwdata[gpio_w-1 : 0];
        end
    end

    always_comb begin
        ahb_s.hrdata = '0;                          // unknown offsets read zero
        if (act_r) begin
            case (off_r)
                gpio_gpi_off : ahb_s.hrdata = ahb_word_t'(gpi_s);
                gpio_gpo_off : ahb_s.hrdata = ahb_word_t'(gpo_r);
                gpio_gpd_off : ahb_s.hrdata = ahb_word_t'(gpd_r);
                default      : ahb_s.hrdata = '0;
            endcase
        end
    end

    assign ahb_s.hresp  = hresp_okay;
    assign ahb_s.hready = 1'b1;
    assign gpo_o        = gpo_r;
    assign gpd_o        = gpd_r;

    // registers are word wide only
    a_word_size : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        addr_ph |-> ahb_s.hsize == hsize_word);

endmodule : nf_ahb_gpio

`default_nettype wire

// ==== source/nf_ahb_pwm.sv ====
// AHB-Lite PWM generator
`timescale 1ns/1ps
`default_nettype none

module nf_ahb_pwm
    import nf_ahb_pkg::*;
    import nf_periph_pkg::*;
#(
    parameter int pwm_w = 8                         // counter and duty width
)(
    input  logic        clk_i,
    input  logic        rst_n_i,
    nf_ahb_if.slave     ahb_s,
    output logic        pwm_o                       // registered PWM output
);

    logic [pwm_w-1 : 0]     duty_r;                 // high cycles per period
    logic [pwm_w-1 : 0]     cnt_r;                  // free running, wraps at 2^pwm_w
    logic                   pwm_r;
    logic [7 : 0]           off_r;
    logic                   act_r;
    logic                   wr_r;
    logic                   addr_ph;

    assign addr_ph = ahb_s.hsel && (ahb_s.htrans == htrans_nonseq);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            act_r <= 1'b0;
            wr_r  <= 1'b0;
        end else begin
            act_r <= addr_ph;
            wr_r  <= addr_ph && ahb_s.hwrite;
        end
    end

    always_ff @(posedge clk_i) begin
        if (addr_ph)
            off_r <= ahb_s.haddr[7 : 0];
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            duty_r <= '0;
        end else if (wr_r && off_r == pwm_duty_off) begin
            duty_r <= ahb_s.hwdata[pwm_w-1 : 0];    // takes effect after data phase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_r <= '0;
            pwm_r <= 1'b0;
        end else begin
            cnt_r <= cnt_r + 1'b1;                  // natural wrap
            pwm_r <= (cnt_r < duty_r);              // duty 0 gives constant low
        end
    end

    assign ahb_s.hrdata = (act_r && off_r == pwm_duty_off) ? ahb_word_t'(duty_r) : '0;
    assign ahb_s.hresp  = hresp_okay;
    assign ahb_s.hready = 1'b1;
    assign pwm_o        = pwm_r;

endmodule : nf_ahb_pwm

`default_nettype wire

// ==== source/nf_top.sv ====
// peripheral subsystem top
`timescale 1ns/1ps
`default_nettype none

module nf_top
    import nf_ahb_pkg::*;
    import nf_periph_pkg::*;
#(
    parameter int ram_depth = 256,                  // RAM words
    parameter int gpio_w    = $bits(gpio_word_t),   // GPIO pins
    parameter int pwm_w     = $bits(pwm_duty_t)     // PWM resolution
)(
    input  logic                clk_i,
    input  logic                rst_n_i,
    // core data port
    input  ahb_word_t           addr_dm_i,
    input  ahb_word_t           wd_dm_i,
    input  logic                we_dm_i,
    input  logic                req_dm_i,
    output ahb_word_t           rd_dm_o,
    output logic                req_ack_dm_o,
    // pins
    input  logic [gpio_w-1 : 0] gpio_i_i,
    output logic [gpio_w-1 : 0] gpio_o_o,
    output logic [gpio_w-1 : 0] gpio_d_o,
    output logic                pwm_o
);

    nf_ahb_if ram_if ();                            // region 0
    nf_ahb_if gpio_if ();                           // region 1
    nf_ahb_if pwm_if ();                            // region 2

    nf_ahb_router nf_ahb_router_0 (
        .clk_i          ( clk_i         ),
        .rst_n_i        ( rst_n_i       ),
        .addr_dm_i      ( addr_dm_i     ),
        .wd_dm_i        ( wd_dm_i       ),
        .we_dm_i        ( we_dm_i       ),
        .req_dm_i       ( req_dm_i      ),
        .rd_dm_o        ( rd_dm_o       ),
        .req_ack_dm_o   ( req_ack_dm_o  ),
        .ram_m          ( ram_if        ),
        .gpio_m         ( gpio_if       ),
        .pwm_m          ( pwm_if        )
    );

    nf_ahb_ram #(
        .ram_depth      ( ram_depth     )
    ) nf_ahb_ram_0 (
        .clk_i          ( clk_i         ),
        .rst_n_i        ( rst_n_i       ),
        .ahb_s          ( ram_if        )
    );

    nf_ahb_gpio #(
        .gpio_w         ( gpio_w        )
    ) nf_ahb_gpio_0 (
        .clk_i          ( clk_i         ),
        .rst_n_i        ( rst_n_i       ),
        .ahb_s          ( gpio_if       ),
        .gpi_i          ( gpio_i_i      ),
        .gpo_o          ( gpio_o_o      ),
        .gpd_o          ( gpio_d_o      )
    );

    nf_ahb_pwm #(
        .pwm_w          ( pwm_w         )
    ) nf_ahb_pwm_0 (
        .clk_i          ( clk_i         ),          // shares bus clock
        .rst_n_i        ( rst_n_i       ),
        .ahb_s          ( pwm_if        ),
        .pwm_o          ( pwm_o         )
    );

endmodule : nf_top

`default_nettype wire

// ==== dv/nf_tb_clk.sv ====
// testbench clock source
`timescale 1ns/1ps
`default_nettype none

module nf_tb_clk #(
    parameter int period_ns = 10                    // full clock period
)(
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;    // 50 % duty
    end

endmodule : nf_tb_clk

`default_nettype wire

// ==== dv/nf_tb.sv ====
// peripheral subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module nf_tb
    import nf_ahb_pkg::*;
    import nf_periph_pkg::*;
;

    localparam int        ack_lat_c    = 3;         // falling edges from drive to ack
    localparam int        ack_tmo_c    = 50;        // ack wait limit in cycles
    localparam int        gpi_settle_c = 4;         // covers the two-flop sync
    localparam int        pwm_period_c = 256;       // 2^pwm_w cycles
    localparam ahb_word_t ram_base     = 32'h0000_0000;
    localparam ahb_word_t gpio_base    = 32'h0001_0000;
    localparam ahb_word_t pwm_base     = 32'h0002_0000;
    localparam ahb_word_t none_base    = 32'h0003_0000;  // region 3

    typedef enum logic [2 : 0] {
        op_wr,                                      // bus write
        op_rd,                                      // bus read with data compare
        op_gpi,                                     // set input pins
        op_pins,                                    // check gpo/gpd pins
        op_pwm                                      // count pwm_o high cycles
    } op_t;

    typedef struct packed {
        op_t       op;
        ahb_word_t addr;
        ahb_word_t wd;
        ahb_word_t exp;                             // pins as {gpd, gpo} in low bytes
    } entry_t;

    logic       clk;
    logic       rst_n;
    ahb_word_t  addr_dm;
    ahb_word_t  wd_dm;
    logic       we_dm;
    logic       req_dm;
    ahb_word_t  rd_dm;
    logic       req_ack_dm;
    gpio_word_t gpio_i;
    gpio_word_t gpio_o;
    gpio_word_t gpio_d;
    logic       pwm;

    entry_t     tbl[$];                             // stimulus table
    ahb_word_t  rnd[4];                             // random RAM words
    ahb_word_t  ram_addr[4];
    integer     seed = 32'hb8c0_2ec0;
    int         err_val = 0;                        // wrong values
    int         err_tmo = 0;                        // missing acks

    nf_tb_clk #(.period_ns(10)) nf_tb_clk_0 (.clk_o(clk));

    nf_top #(
        .ram_depth      ( 256           ),
        .gpio_w         ( 8             ),
        .pwm_w          ( 8             )
    ) uut (
        .clk_i          ( clk           ),
        .rst_n_i        ( rst_n         ),
        .addr_dm_i      ( addr_dm       ),
        .wd_dm_i        ( wd_dm         ),
        .we_dm_i        ( we_dm         ),
        .req_dm_i       ( req_dm        ),
        .rd_dm_o        ( rd_dm         ),
        .req_ack_dm_o   ( req_ack_dm    ),
        .gpio_i_i       ( gpio_i        ),
        .gpio_o_o       ( gpio_o        ),
        .gpio_d_o       ( gpio_d        ),
        .pwm_o          ( pwm           )
    );

    task automatic check_word(input string name, input ahb_word_t act, input ahb_word_t exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, act, exp);
            err_val++;
        end
    endtask

    task automatic check_gpio(input string name, input gpio_word_t act, input gpio_word_t exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, act, exp);
            err_val++;
        end
    endtask

    task automatic check_duty(input string name, input pwm_duty_t act, input pwm_duty_t exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, act, exp);
            err_val++;
        end
    endtask

    task automatic add_entry(input op_t op, input ahb_word_t addr, input ahb_word_t wd,
                             input ahb_word_t exp);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.wd   = wd;
        e.exp  = exp;
        tbl.push_back(e);
    endtask

    // one request held until ack
    // lat counts falling edges from the drive edge
    task automatic bus_access(input logic we, input ahb_word_t addr, input ahb_word_t wd,
                              output ahb_word_t rd, output int lat);
        int  n;
        logic got;
        n   = 0;
        got = 1'b0;
        rd  = '0;
        @(posedge clk);
        addr_dm <= addr;
        wd_dm   <= wd;
        we_dm   <= we;
        req_dm  <= 1'b1;
        while (!got && n < ack_tmo_c) begin
            @(negedge clk);
            n++;
            if (req_ack_dm) begin
                got = 1'b1;
                rd  = rd_dm;                        // valid in ack cycle
            end
        end
        lat = n;
        @(posedge clk);
        req_dm <= 1'b0;
        we_dm  <= 1'b0;
        if (!got) begin
            $display("Timeout: no ack for access to address 0x%h within %0d cycles",
                     addr, ack_tmo_c);
            err_tmo++;
        end
    endtask

    task automatic count_pwm(output int high);
        high = 0;
        @(posedge clk);                             // new duty reaches pwm_o
        repeat (pwm_period_c) begin
            @(negedge clk);
            if (pwm)
                high++;
        end
    endtask

    initial begin
        entry_t    e;
        ahb_word_t rd;
        int        lat;
        int        high;
        rst_n   = 1'b0;
        addr_dm = '0;
        wd_dm   = '0;
        we_dm   = 1'b0;
        req_dm  = 1'b0;
        gpio_i  = '0;

        ram_addr = '{32'h10, 32'h44, 32'h100, 32'h3fc};
        for (int i = 0; i < 4; i++)
            rnd[i] = $random(seed);
        for (int i = 0; i < 4; i++)
            add_entry(op_wr, ram_base + ram_addr[i], rnd[i], '0);
        add_entry(op_rd, ram_base + ram_addr[2], '0, rnd[2]);   // other order
        add_entry(op_rd, ram_base + ram_addr[0], '0, rnd[0]);
        add_entry(op_rd, ram_base + ram_addr[3], '0, rnd[3]);
        add_entry(op_rd, ram_base + ram_addr[1], '0, rnd[1]);
        add_entry(op_wr, gpio_base + gpio_gpo_off, 32'h1234_56a5, '0);  // upper bits dropped
        add_entry(op_wr, gpio_base + gpio_gpd_off, 32'h0000_003c, '0);
        add_entry(op_pins, '0, '0, 32'h0000_3ca5);
        add_entry(op_rd, gpio_base + gpio_gpo_off, '0, 32'h0000_00a5);
        add_entry(op_rd, gpio_base + gpio_gpd_off, '0, 32'h0000_003c);
        add_entry(op_gpi, '0, 32'h0000_005a, '0);
        add_entry(op_rd, gpio_base + gpio_gpi_off, '0, 32'h0000_005a);
        for (int i = 0; i < 3; i++) begin
            ahb_word_t d;
            d = (i == 0) ? 32'd0 : (i == 1) ? 32'd64 : 32'd200;
            add_entry(op_wr, pwm_base + pwm_duty_off, d, '0);
            add_entry(op_pwm, '0, '0, d);
            add_entry(op_rd, pwm_base + pwm_duty_off, '0, d);
        end
        add_entry(op_rd, none_base, '0, '0);        // unmapped reads zero
        add_entry(op_wr, none_base + ram_addr[0], 32'hdead_beef, '0);  // RAM alias
        add_entry(op_wr, none_base + gpio_gpo_off, 32'h0000_00ff, '0); // gpo alias
        add_entry(op_wr, none_base + pwm_duty_off, 32'h0000_0011, '0); // duty alias
        add_entry(op_rd, ram_base + ram_addr[0], '0, rnd[0]);
        add_entry(op_rd, gpio_base + gpio_gpo_off, '0, 32'h0000_00a5);
        add_entry(op_rd, pwm_base + pwm_duty_off, '0, 32'd200);
        add_entry(op_pins, '0, '0, 32'h0000_3ca5);

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_gpio("gpio_o_o", gpio_o, '0);         // reset state
        check_gpio("gpio_d_o", gpio_d, '0);
        check_word("pwm_o", ahb_word_t'(pwm), '0);
        check_word("req_ack_dm_o", ahb_word_t'(req_ack_dm), '0);
        check_word("rd_dm_o", rd_dm, '0);

        for (int i = 0; i < tbl.size() && err_tmo == 0; i++) begin
            e = tbl[i];
            case (e.op)
                op_wr, op_rd : begin
                    bus_access(e.op == op_wr, e.addr, e.wd, rd, lat);
                    if (err_tmo == 0) begin
                        check_word("req_ack_dm_o latency", ahb_word_t'(lat),
                                   ahb_word_t'(ack_lat_c));
                        if (e.op == op_rd)
                            check_word($sformatf("rd_dm_o @0x%h", e.addr), rd, e.exp);
                    end
                end
                op_gpi : begin
                    @(posedge clk);
                    gpio_i <= gpio_word_t'(e.wd);
                    repeat (gpi_settle_c) @(posedge clk);
                end
                op_pins : begin
                    @(negedge clk);
                    check_gpio("gpio_o_o", gpio_o, e.exp[7 : 0]);
                    check_gpio("gpio_d_o", gpio_d, e.exp[15 : 8]);
                end
                default : begin
                    count_pwm(high);
                    check_duty("pwm_o high count", pwm_duty_t'(high), pwm_duty_t'(e.exp));
                end
            endcase
        end

        $display("errors: %0d wrong values, %0d timeouts", err_val, err_tmo);
        if (err_val == 0 && err_tmo == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : nf_tb

`default_nettype wire

// ==== flist.f ====
source/nf_ahb_pkg.sv
source/nf_periph_pkg.sv
source/nf_ahb_if.sv
source/nf_ahb_router.sv
source/nf_ahb_ram.sv
source/nf_ahb_gpio.sv
source/nf_ahb_pwm.sv
source/nf_top.sv
dv/nf_tb_clk.sv
dv/nf_tb.sv

// ==== Makefile ====
# Verilator simulation of the peripheral subsystem

TOP := nf_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -Wno-fatal --top-module $(TOP) \
		-f flist.f -Mdir obj_dir

run: compile
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
